// ==== rtl/accel_cfg.svh ====
`ifndef ACCEL_CFG_SVH
`define ACCEL_CFG_SVH

// number of accelerator tiles behind the link
`define ACCEL_NUM_TILES 4

// payload and packet address widths
`define ACCEL_DATA_W 32
`define ACCEL_ADDR_W 16

// request address, low bits pick the register and high bits pick the tile
`define ACCEL_REQ_ADDR_W 4
`define ACCEL_REG_W 2
`define ACCEL_TILE_W (`ACCEL_REQ_ADDR_W - `ACCEL_REG_W)

// destination coordinate widths
`define ACCEL_X_W 4
`define ACCEL_Y_W 4

// collector queue depth per tile, each tile may have this many packets in flight
`define ACCEL_QUEUE_ELS 4
`define ACCEL_CREDIT_MAX `ACCEL_QUEUE_ELS
`define ACCEL_CREDIT_W $clog2(`ACCEL_CREDIT_MAX + 1)

`endif

// ==== rtl/accel_pkg.sv ====
`include "accel_cfg.svh"

package accel_pkg;

   // register select carried in the low request address bits
   typedef enum logic [`ACCEL_REG_W-1:0]
   {
      ACCEL_REG_DEST_ADDR  = 2'd0,
      ACCEL_REG_DEST_COORD = 2'd1,
      ACCEL_REG_FORWARD    = 2'd2
   } accel_reg_e;

   // one incoming data word
   // register 1 reads it as a y/x coordinate, registers 0 and 2 take it raw
   typedef union packed
   {
      logic [`ACCEL_DATA_W-1:0] raw;
      struct packed
      {
         logic [`ACCEL_DATA_W-`ACCEL_Y_W-`ACCEL_X_W-1:0] pad;
         logic [`ACCEL_Y_W-1:0]                          y;
         logic [`ACCEL_X_W-1:0]                          x;
      } coord;
   } accel_word_u;

endpackage

// ==== rtl/accel_link_if.sv ====
`timescale 1ns/1ps
`include "accel_cfg.svh"

// one request or packet link
// the sender holds v and the fields until yumi, and yumi ends the transfer
interface accel_link_if;

   logic                      v;
   logic                      yumi;
   logic [`ACCEL_ADDR_W-1:0]  addr;
   logic [`ACCEL_DATA_W-1:0]  data;
   logic [`ACCEL_X_W-1:0]     dest_x;
   logic [`ACCEL_Y_W-1:0]     dest_y;
   logic [`ACCEL_TILE_W-1:0]  src;

   modport send
   (
      output v, addr, data, dest_x, dest_y, src,
      input  yumi
   );

   modport recv
   (
      input  v, addr, data, dest_x, dest_y, src,
      output yumi
   );

endinterface

// ==== rtl/accel_dispatch.sv ====
`timescale 1ns/1ps
`include "accel_cfg.svh"

module accel_dispatch
   (
      input  logic                          clk_i,
      input  logic                          arst_n_i,
      input  logic                          in_v_i,
      input  logic [`ACCEL_REQ_ADDR_W-1:0]  in_addr_i,
      input  logic [`ACCEL_DATA_W-1:0]      in_data_i,
      output logic                          in_yumi_o,
      accel_link_if.send                    tile_o [`ACCEL_NUM_TILES]
   );

   localparam int n_lp      = `ACCEL_NUM_TILES;
   localparam int reg_w_lp  = `ACCEL_REG_W;
   localparam int tile_w_lp = `ACCEL_TILE_W;
   localparam int addr_w_lp = `ACCEL_ADDR_W;

   logic [tile_w_lp-1:0] tile_sel;
   logic [reg_w_lp-1:0]  reg_sel;
   logic [n_lp-1:0]      tile_yumi;

   assign tile_sel = in_addr_i[`ACCEL_REQ_ADDR_W-1:reg_w_lp];
   assign reg_sel  = in_addr_i[reg_w_lp-1:0];

   for (genvar i = 0; i < n_lp; i++)
   begin : g_tile
      // only the addressed tile sees valid, the rest see the request idle
      assign tile_o[i].v    = in_v_i && (tile_sel == tile_w_lp'(i));
      assign tile_o[i].addr = addr_w_lp'(reg_sel);
      assign tile_o[i].data = in_data_i;

      // request links carry no routing fields
      assign tile_o[i].dest_x = '0;
      assign tile_o[i].dest_y = '0;
      assign tile_o[i].src    = '0;

      assign tile_yumi[i] = tile_o[i].yumi;
   end

   // the unselected tiles hold yumi low, so an or reduction is enough
   assign in_yumi_o = |tile_yumi;

   a_tile_in_range : assert property
   (
      @(posedge clk_i) disable iff (!arst_n_i)
      in_v_i |-> (int'(tile_sel) < n_lp)
   );

   // the tiles must never acknowledge a request that is not offered
   a_yumi_needs_v : assert property
   (
      @(posedge clk_i) disable iff (!arst_n_i)
      in_yumi_o |-> in_v_i
   );

endmodule

// ==== rtl/accel_tile.sv ====
`timescale 1ns/1ps
`include "accel_cfg.svh"

module accel_tile
   import accel_pkg::*;
   (
      input  logic                     clk_i,
      input  logic                     arst_n_i,
      input  logic [`ACCEL_TILE_W-1:0] tile_idx_i,
      accel_link_if.recv               req_i,
      accel_link_if.send               pkt_o,
      input  logic                     credit_i
   );

   localparam int addr_w_lp   = `ACCEL_ADDR_W;
   localparam int reg_w_lp    = `ACCEL_REG_W;
   localparam int credit_w_lp = `ACCEL_CREDIT_W;
   localparam logic [credit_w_lp-1:0] credit_max_lp = credit_w_lp'(`ACCEL_CREDIT_MAX);

   accel_word_u              word;
   accel_reg_e               reg_sel;
   logic                     addr_we;
   logic                     coord_we;
   logic                     fwd_req;
   logic [addr_w_lp-1:0]     dest_addr_r;
   logic [`ACCEL_Y_W-1:0]    dest_y_r;
   logic [`ACCEL_X_W-1:0]    dest_x_r;
   logic [credit_w_lp-1:0]   credit_cnt_r;

   assign word    = req_i.data;
   assign reg_sel = accel_reg_e'(req_i.addr[reg_w_lp-1:0]);

   assign addr_we  = req_i.v && (reg_sel == ACCEL_REG_DEST_ADDR);
   assign coord_we = req_i.v && (reg_sel == ACCEL_REG_DEST_COORD);
   assign fwd_req  = req_i.v && (reg_sel == ACCEL_REG_FORWARD);

   // configuration writes complete at once
   // a forward completes when the collector takes the packet
   assign req_i.yumi = addr_we | coord_we | pkt_o.yumi;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         dest_addr_r <= '0;
         dest_y_r    <= '0;
         dest_x_r    <= '0;
      end
      else
      begin
         if (addr_we)
         begin
            dest_addr_r <= word.raw[addr_w_lp-1:0];
         end
         if (coord_we)
         begin
            dest_y_r <= word.coord.y;
            dest_x_r <= word.coord.x;
         end
      end
   end

   // outgoing packet, only offered while the collector has room for it
   assign pkt_o.v      = fwd_req && (credit_cnt_r != '0);
   assign pkt_o.addr   = dest_addr_r;
   assign pkt_o.data   = word.raw;
   assign pkt_o.dest_x = dest_x_r;
   assign pkt_o.dest_y = dest_y_r;
   assign pkt_o.src    = tile_idx_i;

   // one credit per free slot in this tile's collector queue
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         credit_cnt_r <= credit_max_lp;
      end
      else if (pkt_o.yumi != credit_i)
      begin
         if (pkt_o.yumi)
         begin
            credit_cnt_r <= credit_cnt_r - 1'b1;
         end
         else
         begin
            credit_cnt_r <= credit_cnt_r + 1'b1;
         end
      end
   end

   a_reg_sel_legal : assert property
   (
      @(posedge clk_i) disable iff (!arst_n_i)
      req_i.v |-> (req_i.addr[reg_w_lp-1:0] != {reg_w_lp{1'b1}})
   );

   a_no_underflow : assert property
   (
      @(posedge clk_i) disable iff (!arst_n_i)
      (credit_cnt_r == '0) |-> !pkt_o.yumi
   );

   // a returned credit never pushes the count past the queue depth
   a_no_overflow : assert property
   (
      @(posedge clk_i) disable iff (!arst_n_i)
      (credit_i && !pkt_o.yumi) |-> (credit_cnt_r < credit_max_lp)
   );

endmodule

// ==== rtl/accel_collect.sv ====
`timescale 1ns/1ps
`include "accel_cfg.svh"

module accel_collect
   (
      input  logic                        clk_i,
      input  logic                        arst_n_i,
      accel_link_if.recv                  pkt_i [`ACCEL_NUM_TILES],
      output logic [`ACCEL_NUM_TILES-1:0] credit_o,
      output logic                        out_v_o,
      output logic [`ACCEL_ADDR_W-1:0]    out_addr_o,
      output logic [`ACCEL_DATA_W-1:0]    out_data_o,
      output logic [`ACCEL_X_W-1:0]       out_dest_x_o,
      output logic [`ACCEL_Y_W-1:0]       out_dest_y_o,
      output logic [`ACCEL_TILE_W-1:0]    out_src_o,
      input  logic                        out_yumi_i
   );

   localparam int n_lp      = `ACCEL_NUM_TILES;
   localparam int tile_w_lp = `ACCEL_TILE_W;
   localparam int els_lp    = `ACCEL_QUEUE_ELS;
   localparam int ptr_w_lp  = $clog2(els_lp);
   localparam int cnt_w_lp  = $clog2(els_lp + 1);
   localparam int pkt_w_lp  = `ACCEL_TILE_W + `ACCEL_Y_W + `ACCEL_X_W
                              + `ACCEL_ADDR_W + `ACCEL_DATA_W;

   logic [n_lp-1:0]                nonempty;
   logic [n_lp-1:0]                pop;
   logic [n_lp-1:0]                credit_r;
   logic [n_lp-1:0][pkt_w_lp-1:0]  head_pkt;
   logic [tile_w_lp-1:0]           rr_ptr_r;
   logic [tile_w_lp-1:0]           search_idx;
   logic [tile_w_lp-1:0]           grant_idx;
   logic [tile_w_lp-1:0]           lock_idx_r;
   logic                           search_v;
   logic                           lock_r;

   function automatic logic [ptr_w_lp-1:0] next_ptr(input logic [ptr_w_lp-1:0] ptr);
      if (ptr == ptr_w_lp'(els_lp - 1))
      begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   for (genvar i = 0; i < n_lp; i++)
   begin : g_queue
      logic [pkt_w_lp-1:0]  mem [els_lp];
      logic [ptr_w_lp-1:0]  wr_ptr_r;
      logic [ptr_w_lp-1:0]  rd_ptr_r;
      logic [cnt_w_lp-1:0]  count_r;
      logic                 push;
      logic                 full;

      // the tile only sends with a credit in hand, so every offer is taken
      assign push           = pkt_i[i].v;
      assign pkt_i[i].yumi  = push;
      assign full           = (count_r == cnt_w_lp'(els_lp));
      assign nonempty[i]    = (count_r != '0);
      assign pop[i]         = out_v_o && out_yumi_i && (grant_idx == tile_w_lp'(i));
      assign head_pkt[i]    = mem[rd_ptr_r];

      always_ff @(posedge clk_i)
      begin
         if (push)
         begin
            mem[wr_ptr_r] <= {pkt_i[i].src, pkt_i[i].dest_y, pkt_i[i].dest_x,
                              pkt_i[i].addr, pkt_i[i].data};
         end
      end

      always_ff @(posedge clk_i or negedge arst_n_i)
      begin
         if (!arst_n_i)
         begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
         end
         else
         begin
            if (push)
            begin
               wr_ptr_r <= next_ptr(wr_ptr_r);
            end
            if (pop[i])
            begin
               rd_ptr_r <= next_ptr(rd_ptr_r);
            end
            if (push != pop[i])
            begin
               count_r <= push ? count_r + 1'b1 : count_r - 1'b1;
            end
         end
      end

      a_no_push_full : assert property
      (
         @(posedge clk_i) disable iff (!arst_n_i)
         push |-> !full
      );
   end

   // first nonempty queue at or after the round-robin pointer
   always_comb
   begin
      logic [tile_w_lp-1:0] cand;
      search_v   = 1'b0;
      search_idx = rr_ptr_r;
      cand       = rr_ptr_r;
      for (int k = n_lp - 1; k >= 0; k--)
      begin
         cand = tile_w_lp'((int'(rr_ptr_r) + k) % n_lp);
         if (nonempty[cand])
         begin
            search_v   = 1'b1;
            search_idx = cand;
         end
      end
   end

   // once a head is shown it stays until yumi, even if a closer queue fills
   assign grant_idx = lock_r ? lock_idx_r : search_idx;
   assign out_v_o   = lock_r | search_v;

   assign {out_src_o, out_dest_y_o, out_dest_x_o, out_addr_o, out_data_o} = head_pkt[grant_idx];

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         rr_ptr_r   <= '0;
         lock_r     <= 1'b0;
         lock_idx_r <= '0;
         credit_r   <= '0;
      end
      else
      begin
         lock_r     <= out_v_o && !out_yumi_i;
         lock_idx_r <= grant_idx;
         credit_r   <= pop;
         if (out_v_o && out_yumi_i)
         begin
            rr_ptr_r <= tile_w_lp'((int'(grant_idx) + 1) % n_lp);
         end
      end
   end

   assign credit_o = credit_r;

endmodule

// ==== rtl/accel_top.sv ====
`timescale 1ns/1ps
`include "accel_cfg.svh"

module accel_top
   (
      input  logic                          clk_i,
      input  logic                          arst_n_i,

      // request side
      input  logic                          in_v_i,
      input  logic [`ACCEL_REQ_ADDR_W-1:0]  in_addr_i,
      input  logic [`ACCEL_DATA_W-1:0]      in_data_i,
      output logic                          in_yumi_o,

      // packet output side
      output logic                          out_v_o,
      output logic [`ACCEL_ADDR_W-1:0]      out_addr_o,
      output logic [`ACCEL_DATA_W-1:0]      out_data_o,
      output logic [`ACCEL_X_W-1:0]         out_dest_x_o,
      output logic [`ACCEL_Y_W-1:0]         out_dest_y_o,
      output logic [`ACCEL_TILE_W-1:0]      out_src_o,
      input  logic                          out_yumi_i
   );

   localparam int n_lp      = `ACCEL_NUM_TILES;
   localparam int tile_w_lp = `ACCEL_TILE_W;

   accel_link_if req_link [n_lp] ();
   accel_link_if pkt_link [n_lp] ();

   logic [n_lp-1:0] credit;

   accel_dispatch i_accel_dispatch
   (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .in_v_i    (in_v_i),
      .in_addr_i (in_addr_i),
      .in_data_i (in_data_i),
      .in_yumi_o (in_yumi_o),
      .tile_o    (req_link)
   );

   for (genvar i = 0; i < n_lp; i++)
   begin : g_tile
      accel_tile i_accel_tile
      (
         .clk_i      (clk_i),
         .arst_n_i   (arst_n_i),
         .tile_idx_i (tile_w_lp'(i)),
         .req_i      (req_link[i]),
         .pkt_o      (pkt_link[i]),
         .credit_i   (credit[i])
      );
   end

   accel_collect i_accel_collect
   (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .pkt_i        (pkt_link),
      .credit_o     (credit),
      .out_v_o      (out_v_o),
      .out_addr_o   (out_addr_o),
      .out_data_o   (out_data_o),
      .out_dest_x_o (out_dest_x_o),
      .out_dest_y_o (out_dest_y_o),
      .out_src_o    (out_src_o),
      .out_yumi_i   (out_yumi_i)
   );

endmodule

// ==== verification/accel_tb.sv ====
`timescale 1ns/1ps
`include "accel_cfg.svh"

module accel_tb;

   localparam int n_lp      = `ACCEL_NUM_TILES;
   localparam int tile_w_lp = `ACCEL_TILE_W;
   localparam int reg_w_lp  = `ACCEL_REG_W;
   localparam int max_req_lp = 64;
   localparam int max_exp_lp = 32;

   logic                          clk_i = 1'b0;
   logic                          arst_n_i;
   logic                          in_v_i;
   logic [`ACCEL_REQ_ADDR_W-1:0]  in_addr_i;
   logic [`ACCEL_DATA_W-1:0]      in_data_i;
   logic                          in_yumi_o;
   logic                          out_v_o;
   logic [`ACCEL_ADDR_W-1:0]      out_addr_o;
   logic [`ACCEL_DATA_W-1:0]      out_data_o;
   logic [`ACCEL_X_W-1:0]         out_dest_x_o;
   logic [`ACCEL_Y_W-1:0]         out_dest_y_o;
   logic [`ACCEL_TILE_W-1:0]      out_src_o;
   logic                          out_yumi_i;

   // request list where kind is W for a write or P for a back-pressure hold
   logic [7:0]  req_kind [max_req_lp];
   int          req_tile [max_req_lp];
   int          req_reg  [max_req_lp];
   logic [31:0] req_data [max_req_lp];
   int          req_cnt = 0;

   // expected packets in one queue per source tile
   logic [`ACCEL_Y_W-1:0]    exp_y    [n_lp][max_exp_lp];
   logic [`ACCEL_X_W-1:0]    exp_x    [n_lp][max_exp_lp];
   logic [`ACCEL_ADDR_W-1:0] exp_addr [n_lp][max_exp_lp];
   logic [`ACCEL_DATA_W-1:0] exp_data [n_lp][max_exp_lp];
   int exp_wr [n_lp] = '{default: 0};
   int exp_rd [n_lp] = '{default: 0};

   int          mismatch_cnt  = 0;
   int          other_err_cnt = 0;
   int          line_cnt      = 0;
   int          cycle_cnt     = 0;
   int          cycle_limit   = 0;
   int          hold_until    = 0;
   logic        yumi_allow    = 1'b0;
   logic [15:0] lfsr_state    = 16'd9;

   accel_top i_accel_top
   (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .in_v_i       (in_v_i),
      .in_addr_i    (in_addr_i),
      .in_data_i    (in_data_i),
      .in_yumi_o    (in_yumi_o),
      .out_v_o      (out_v_o),
      .out_addr_o   (out_addr_o),
      .out_data_o   (out_data_o),
      .out_dest_x_o (out_dest_x_o),
      .out_dest_y_o (out_dest_y_o),
      .out_src_o    (out_src_o),
      .out_yumi_i   (out_yumi_i)
   );

   always #10 clk_i = ~clk_i;

   // yumi is only offered while the DUT shows a packet
   assign out_yumi_i = out_v_o & yumi_allow;

   // 16-bit Fibonacci LFSR with taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic bit all_drained();
      for (int t = 0; t < n_lp; t++)
      begin
         if (exp_rd[t] != exp_wr[t])
         begin
            return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp)
      begin
         mismatch_cnt++;
         $display("mismatch at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic print_summary();
      $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_err_cnt);
   endtask

   task automatic read_golden(output bit ok);
      int          fd;
      int          code;
      int          a;
      int          b;
      int          c;
      logic [31:0] h0;
      logic [31:0] h1;
      logic [63:0] tag;
      logic [8*160-1:0] rest;
      ok = 1'b0;
      fd = $fopen("verification/accel_golden.txt", "r");
      if (fd == 0)
      begin
         return;
      end
      while (!$feof(fd))
      begin
         code = $fscanf(fd, "%s", tag);
         if (code != 1)
         begin
            break;
         end
         if (tag == "#")
         begin
            code = $fgets(rest, fd);
            line_cnt++;
         end
         else if (tag == "W" || tag == "P")
         begin
            if (tag == "W")
            begin
               code = $fscanf(fd, "%d %d %h", a, b, h0);
            end
            else
            begin
               code = $fscanf(fd, "%d", h0);
            end
            req_kind[req_cnt] = tag[7:0];
            req_tile[req_cnt] = a;
            req_reg[req_cnt]  = b;
            req_data[req_cnt] = h0;
            req_cnt++;
            line_cnt++;
         end
         else if (tag == "E")
         begin
            code = $fscanf(fd, "%d %d %d %h %h", a, b, c, h0, h1);
            exp_y[a][exp_wr[a]]    = b;
            exp_x[a][exp_wr[a]]    = c;
            exp_addr[a][exp_wr[a]] = h0;
            exp_data[a][exp_wr[a]] = h1;
            exp_wr[a]++;
            line_cnt++;
         end
         else
         begin
            other_err_cnt++;
            $display("error: unknown record type in golden file");
         end
      end
      $fclose(fd);
      ok = 1'b1;
   endtask

   // drive one request and hold it until the DUT takes it
   task automatic send_request(input int tile, input int regsel, input logic [31:0] data);
      in_v_i    <= 1'b1;
      in_addr_i <= {tile[tile_w_lp-1:0], regsel[reg_w_lp-1:0]};
      in_data_i <= data;
      do
      begin
         @(posedge clk_i);
      end
      while (!in_yumi_o);
   endtask

   // cycle count, back-pressure and output checking
   always @(posedge clk_i)
   begin
      int src;
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt < hold_until)
      begin
         yumi_allow <= 1'b0;
      end
      else
      begin
         lfsr_state = lfsr_next(lfsr_state);
         yumi_allow <= lfsr_state[0];
      end

      if (arst_n_i && out_v_o && out_yumi_i)
      begin
         src = out_src_o;
         if (exp_rd[src] == exp_wr[src])
         begin
            other_err_cnt++;
            $display("error: unexpected packet from tile %0d at %0t ns", src, $time);
         end
         else
         begin
            check_value("packet data", out_data_o, exp_data[src][exp_rd[src]]);
            check_value("packet addr", out_addr_o, exp_addr[src][exp_rd[src]]);
            check_value("packet dest_y", out_dest_y_o, exp_y[src][exp_rd[src]]);
            check_value("packet dest_x", out_dest_x_o, exp_x[src][exp_rd[src]]);
            exp_rd[src] <= exp_rd[src] + 1;
         end
      end

      if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
      begin
         other_err_cnt++;
         $display("error: run stopped after %0d cycles without finishing", cycle_cnt);
         for (int t = 0; t < n_lp; t++)
         begin
            if (exp_rd[t] != exp_wr[t])
            begin
               $display("error: tile %0d still expects %0d packets", t, exp_wr[t] - exp_rd[t]);
            end
         end
         print_summary();
         $display("TEST FAILED");
         $finish;
      end
   end

   initial
   begin
      bit ok;
      arst_n_i  = 1'b0;
      in_v_i    = 1'b0;
      in_addr_i = '0;
      in_data_i = '0;

      read_golden(ok);
      if (!ok)
      begin
         other_err_cnt++;
         $display("error: cannot open verification/accel_golden.txt");
      end
      else
      begin
         cycle_limit = 40 * line_cnt + 200;

         repeat (16) @(posedge clk_i);
         arst_n_i <= 1'b1;

         // nothing may come out before the first request
         repeat (8)
         begin
            @(posedge clk_i);
            check_value("out_v_o high with no request", out_v_o, 0);
         end

         for (int r = 0; r < req_cnt; r++)
         begin
            if (req_kind[r] == "P")
            begin
               hold_until <= cycle_cnt + int'(req_data[r]);
            end
            else
            begin
               send_request(req_tile[r], req_reg[r], req_data[r]);
            end
         end
         in_v_i <= 1'b0;

         while (!all_drained())
         begin
            @(posedge clk_i);
         end
         // quiet stretch catches any extra packet
         repeat (20) @(posedge clk_i);
      end

      print_summary();
      if (mismatch_cnt == 0 && other_err_cnt == 0)
      begin
         $display("TEST OK");
      end
      else
      begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== verification/accel_golden.txt ====
# W tile reg data : request to a tile register, data in hex
# E src dest_y dest_x addr data : expected packet, addr and data in hex
# P cycles : hold out_yumi_i low for that many cycles
W 0 2 00000011
E 0 0 0 0000 00000011
W 3 2 a5a50003
E 3 0 0 0000 a5a50003
W 1 0 abcd1234
W 1 1 ffffff5a
W 1 2 00000101
E 1 5 10 1234 00000101
W 0 2 00000012
E 0 0 0 0000 00000012
W 2 0 00000040
W 2 2 00000201
E 2 0 0 0040 00000201
W 2 1 00000037
W 2 2 00000202
E 2 3 7 0040 00000202
W 1 0 00005678
W 1 2 00000102
E 1 5 10 5678 00000102
W 3 0 00003300
W 3 1 000000c2
P 60
W 3 2 30000001
E 3 12 2 3300 30000001
W 3 2 30000002
E 3 12 2 3300 30000002
W 3 2 30000003
E 3 12 2 3300 30000003
W 3 2 30000004
E 3 12 2 3300 30000004
W 0 0 00000a00
W 3 2 30000005
E 3 12 2 3300 30000005
W 3 2 30000006
E 3 12 2 3300 30000006
W 0 2 00000013
E 0 0 0 0a00 00000013
W 1 2 00000103
E 1 5 10 5678 00000103
W 2 2 00000203
E 2 3 7 0040 00000203
W 3 2 30000007
E 3 12 2 3300 30000007
W 0 1 00000091
W 0 2 00000014
E 0 9 1 0a00 00000014
W 1 2 00000104
E 1 5 10 5678 00000104
W 2 2 00000205
E 2 3 7 0040 00000205
W 3 2 30000008
E 3 12 2 3300 30000008

// ==== sim.f ====
+incdir+rtl
rtl/accel_pkg.sv
rtl/accel_link_if.sv
rtl/accel_dispatch.sv
rtl/accel_tile.sv
rtl/accel_collect.sv
rtl/accel_top.sv
verification/accel_tb.sv
